// File: Bender.yml
package:
  name: flow_control

sources:
  - files:
      - hw/flow_pkg.sv
      - hw/config_decoder.sv
      - hw/branch_unit.sv
      - hw/branch_arbiter.sv
      - hw/pc_controller.sv
      - hw/flow_control.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/flow_control_tb.sv

// File: hw/branch_arbiter.sv
// Combinational priority pick. Index 0 wins, outputs are all zero when no branch fires
module branch_arbiter
    import flow_pkg::*;
(
    input  branch_result_t results [BRANCH_COUNT],
    output branch_result_t chosen
);

    // ------------------------------
    // LSB-first selection
    // ------------------------------

    logic any_jump;

    // Walk down from the top so the lowest firing index is the last write
    always_comb begin
        chosen = '0;
        for (int i = BRANCH_COUNT - 1; i >= 0; i--) begin
            if (results[i].jump) begin
                chosen = results[i];
            end
        end
    end

    // Plain OR of every unit's jump, kept apart from the selection walk
    always_comb begin
        any_jump = 1'b0;
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            any_jump = any_jump | results[i].jump;
        end
    end

    // Some unit firing must always reach the controller
    always_comb begin
        jump_reaches_out: assert final (chosen.jump == any_jump)
            else $error("arbiter lost or invented a jump");
    end

endmodule

// File: hw/branch_unit.sv
// One branch. Settings are indexed by the aligned thread, so writes and reads share that thread
module branch_unit
    import flow_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  config_write_t           cfg_write,
    input  logic [BRANCH_WIDTH-1:0] branch_index,
    input  logic [THREAD_WIDTH-1:0] thread,
    input  logic [PC_WIDTH-1:0]     pc_current,
    input  logic                    ior,
    input  logic                    ior_previous,
    input  logic [FLAGS_WIDTH-1:0]  flags_previous,
    input  logic [WORD_WIDTH-1:0]   r_previous,
    output branch_result_t          result
);

    // ------------------------------
    // Per-thread settings
    // ------------------------------

    logic [PC_WIDTH-1:0]     origin_q      [THREAD_COUNT];
    logic [PC_WIDTH-1:0]     destination_q [THREAD_COUNT];
    branch_cond_t            cond_q        [THREAD_COUNT];
    logic [THREAD_COUNT-1:0] cancel_flag_q;

    logic write_hit;

    // Window write aimed at this unit
    assign write_hit = cfg_write.wren && (cfg_write.branch == branch_index);

    // Origin, destination and cancel flag
    // Cancel flag only matters once a condition can fire
    always_ff @(posedge clock) begin
        if (write_hit) begin
            case (cfg_write.field)
                FIELD_ORIGIN: begin
                    origin_q[thread] <= cfg_write.data[PC_WIDTH-1:0];
                end
                FIELD_DESTINATION: begin
                    destination_q[thread] <= cfg_write.data[PC_WIDTH-1:0];
                end
                FIELD_CANCEL: begin
                    cancel_flag_q[thread] <= cfg_write.data[0];
                end
                // Condition word lives in the reset block below
                default: begin
                end
            endcase
        end
    end

    // Conditions come out of reset as COND_NEVER so nothing fires
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                cond_q[t] <= '{op: COND_NEVER, flag_sel: '0};
            end
        end else if (write_hit && (cfg_write.field == FIELD_CONDITION)) begin
            // Upper bits of the word are ignored
            cond_q[thread] <= branch_cond_t'(cfg_write.data[COND_BITS-1:0]);
        end
    end

    // ------------------------------
    // Evaluation
    // ------------------------------

    branch_cond_t        cond;
    logic [PC_WIDTH-1:0] origin;
    logic                at_origin;
    logic                r_zero;
    logic                r_negative;
    logic                cond_true;
    logic                jump;

    // Settings of the thread now in the aligned slot
    assign cond       = cond_q[thread];
    assign origin     = origin_q[thread];
    assign at_origin  = (pc_current == origin);

    // Status of the previous result
    assign r_zero     = (r_previous == '0);
    assign r_negative = r_previous[WORD_WIDTH-1];

    always_comb begin
        cond_true = 1'b0;
        case (cond.op)
            COND_NEVER:    cond_true = 1'b0;
            // Unconditional, independent of the previous instruction
            COND_ALWAYS:   cond_true = 1'b1;
            // The rest look at the previous result, valid only if it completed
            COND_ZERO:     cond_true = ior_previous && r_zero;
            COND_NONZERO:  cond_true = ior_previous && !r_zero;
            COND_NEGATIVE: cond_true = ior_previous && r_negative;
            COND_POSITIVE: cond_true = ior_previous && !r_negative && !r_zero;
            COND_FLAG:     cond_true = ior_previous && flags_previous[cond.flag_sel];
            // Unused encoding never fires
            default:       cond_true = 1'b0;
        endcase
    end

    // Not-ready instructions replay and must not branch
    assign jump = ior && at_origin && cond_true;

    assign result.jump        = jump;
    assign result.cancel      = jump && cancel_flag_q[thread];
    assign result.destination = destination_q[thread];

    // Annulling without taking the branch would drop the fall-through
    cancel_needs_jump: assert property (
        @(posedge clock) disable iff (!rst_n)
        result.cancel |-> result.jump
    ) else $error("branch %0d cancels without a jump", branch_index);

endmodule

// File: hw/config_decoder.sv
// Purely combinational. Window base must be aligned to the branch stride for the offset split
module config_decoder
    import flow_pkg::*;
(
    input  logic                  ior_previous,
    input  logic                  cancel_current,
    input  logic [ADDR_WIDTH-1:0] config_addr,
    input  logic [WORD_WIDTH-1:0] config_data,
    output config_write_t         cfg_write
);

    // ------------------------------
    // Window hit and translation
    // ------------------------------

    logic                  write_ok;
    logic                  in_window;
    logic [ADDR_WIDTH-1:0] offset;

    // Writer must have completed its I/O and not been annulled
    assign write_ok = ior_previous && !cancel_current;

    // Bound is inclusive
    assign in_window = (config_addr >= CONFIG_ADDR_BASE) &&
                       (config_addr <= CONFIG_ADDR_BOUND);

    // Zero-based offset into the window
    assign offset = config_addr - CONFIG_ADDR_BASE;

    // ------------------------------
    // Split into branch and field
    // ------------------------------

    assign cfg_write.wren   = write_ok && in_window;
    // Low bits pick the word, next bits pick the branch
    assign cfg_write.field  = offset[FIELD_WIDTH-1:0];
    assign cfg_write.branch = offset[FIELD_WIDTH +: BRANCH_WIDTH];
    // Data goes out unmodified, each unit slices its field
    assign cfg_write.data   = config_data;

    // Decoded index must name an existing unit whenever a write goes out
    always_comb begin
        wren_in_range: assert final (
            !cfg_write.wren ||
            ((config_addr - CONFIG_ADDR_BASE) < ADDR_WIDTH'(BRANCH_COUNT * BRANCH_CONFIG_ENTRIES)
             && int'(cfg_write.branch) < BRANCH_COUNT)
        ) else $error("config write outside branch window");
    end

endmodule

// File: hw/flow_control.sv
// Top of the flow control. All inputs refer to the fetch-aligned instruction of the current thread
module flow_control
    import flow_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    ior,
    input  logic                    ior_previous,
    input  logic                    cancel_current,
    input  logic [FLAGS_WIDTH-1:0]  flags_previous,
    input  logic [WORD_WIDTH-1:0]   r_previous,
    input  logic [ADDR_WIDTH-1:0]   config_addr,
    input  logic [WORD_WIDTH-1:0]   config_data,
    output logic                    cancel,
    output logic [PC_WIDTH-1:0]     pc,
    output logic [THREAD_WIDTH-1:0] thread
);

    config_write_t       cfg_write;
    branch_result_t      results [BRANCH_COUNT];
    branch_result_t      chosen;
    logic [PC_WIDTH-1:0] pc_current;

    // ------------------------------
    // Config window decode
    // ------------------------------

    config_decoder u_config_decoder (
        .ior_previous   (ior_previous),
        .cancel_current (cancel_current),
        .config_addr    (config_addr),
        .config_data    (config_data),
        .cfg_write      (cfg_write)
    );

    // ------------------------------
    // Parallel branch units
    // ------------------------------

    // Each unit owns BRANCH_CONFIG_ENTRIES consecutive window words
    for (genvar i = 0; i < BRANCH_COUNT; i++) begin : gen_branch
        branch_unit u_branch_unit (
            .clock          (clock),
            .rst_n          (rst_n),
            .cfg_write      (cfg_write),
            .branch_index   (BRANCH_WIDTH'(i)),
            .thread         (thread),
            .pc_current     (pc_current),
            .ior            (ior),
            .ior_previous   (ior_previous),
            .flags_previous (flags_previous),
            .r_previous     (r_previous),
            .result         (results[i])
        );
    end

    // ------------------------------
    // Arbitration and PC issue
    // ------------------------------

    branch_arbiter u_branch_arbiter (
        .results (results),
        .chosen  (chosen)
    );

    // Annul comes straight from the winner, same cycle
    assign cancel = chosen.cancel;

    pc_controller u_pc_controller (
        .clock      (clock),
        .rst_n      (rst_n),
        .chosen     (chosen),
        .ior        (ior),
        .pc         (pc),
        .pc_current (pc_current),
        .thread     (thread)
    );

endmodule

// File: hw/flow_pkg.sv
// Shared widths, window map and types. Sized for 4 threads, 2 branches and a 10-bit PC
package flow_pkg;

    // ------------------------------
    // Threads and fetch pipeline
    // ------------------------------

    // Barrel threads, one issue slot each per round
    localparam int THREAD_COUNT = 4;
    localparam int THREAD_WIDTH = 2;
    // PC issue to fetch-aligned evaluation, must be THREAD_COUNT - 1
    localparam int FETCH_DEPTH  = 3;

    // Datapath widths
    localparam int PC_WIDTH     = 10;
    localparam int WORD_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 10;
    localparam int FLAGS_WIDTH  = 4;

    // ------------------------------
    // Branch config window
    // ------------------------------

    localparam int BRANCH_COUNT          = 2;
    localparam int BRANCH_WIDTH          = $clog2(BRANCH_COUNT);
    // Words per branch, consecutive in the window
    localparam int BRANCH_CONFIG_ENTRIES = 4;
    localparam int FIELD_WIDTH           = $clog2(BRANCH_CONFIG_ENTRIES);

    // Window bounds, bound is inclusive
    localparam logic [ADDR_WIDTH-1:0] CONFIG_ADDR_BASE  = 10'h200;
    localparam logic [ADDR_WIDTH-1:0] CONFIG_ADDR_BOUND =
        CONFIG_ADDR_BASE + ADDR_WIDTH'(BRANCH_COUNT * BRANCH_CONFIG_ENTRIES) - 1'b1;

    // Field offsets within one branch
    localparam logic [FIELD_WIDTH-1:0] FIELD_ORIGIN      = 2'd0;
    localparam logic [FIELD_WIDTH-1:0] FIELD_DESTINATION = 2'd1;
    localparam logic [FIELD_WIDTH-1:0] FIELD_CONDITION   = 2'd2;
    // Cancel flag sits in bit 0 of this word
    localparam logic [FIELD_WIDTH-1:0] FIELD_CANCEL      = 2'd3;

    // Start PC per thread, entry 0 is thread 0
    localparam logic [THREAD_COUNT-1:0][PC_WIDTH-1:0] THREAD_START_PC =
        {10'd192, 10'd128, 10'd64, 10'd0};

    // ------------------------------
    // Types
    // ------------------------------

    typedef enum logic [2:0] {
        COND_NEVER    = 3'd0,
        COND_ALWAYS   = 3'd1,
        COND_ZERO     = 3'd2,
        COND_NONZERO  = 3'd3,
        COND_NEGATIVE = 3'd4,
        COND_POSITIVE = 3'd5,
        COND_FLAG     = 3'd6
    } branch_cond_e;

    // Low bits of a condition word, op above flag_sel
    typedef struct packed {
        branch_cond_e op;
        logic [1:0]   flag_sel;
    } branch_cond_t;

    localparam int COND_BITS = $bits(branch_cond_t);

    // Decoded config write, broadcast to every branch unit
    typedef struct packed {
        logic                    wren;
        logic [BRANCH_WIDTH-1:0] branch;
        logic [FIELD_WIDTH-1:0]  field;
        logic [WORD_WIDTH-1:0]   data;
    } config_write_t;

    // One branch decision
    typedef struct packed {
        logic                jump;
        logic                cancel;
        logic [PC_WIDTH-1:0] destination;
    } branch_result_t;

endpackage

// File: hw/pc_controller.sv
// PC ring of THREAD_COUNT slots. No stall input, a not-ready instruction just re-issues its PC
module pc_controller
    import flow_pkg::*;
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  branch_result_t          chosen,
    input  logic                    ior,
    output logic [PC_WIDTH-1:0]     pc,
    output logic [PC_WIDTH-1:0]     pc_current,
    output logic [THREAD_WIDTH-1:0] thread
);

    // Ring only closes when fetch latency fills the other slots
    if (THREAD_COUNT != FETCH_DEPTH + 1) begin : gen_ring_check
        $error("THREAD_COUNT must equal FETCH_DEPTH + 1");
    end

    // ------------------------------
    // Next PC choice
    // ------------------------------

    logic [PC_WIDTH-1:0] pc_next;

    always_comb begin
        if (chosen.jump) begin
            // Taken branch
            pc_next = chosen.destination;
        end else if (ior) begin
            // Fall through, wraps at the top of the PC range
            pc_next = pc_current + PC_WIDTH'(1);
        end else begin
            // I/O not ready, replay same instruction
            pc_next = pc_current;
        end
    end

    // ------------------------------
    // PC ring and fetch delay line
    // ------------------------------

    // fetch_pipe[0] is newest, last stage is the aligned PC
    logic [PC_WIDTH-1:0] fetch_pipe [FETCH_DEPTH];

    // Reset fills the ring backwards from the aligned slot
    // Aligned stage holds thread 0, pc holds the last thread
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= THREAD_START_PC[THREAD_COUNT-1];
            for (int s = 0; s < FETCH_DEPTH; s++) begin
                fetch_pipe[s] <= THREAD_START_PC[FETCH_DEPTH-1-s];
            end
        end else begin
            // Decision for the aligned thread lands in its next issue slot
            pc            <= pc_next;
            fetch_pipe[0] <= pc;
            for (int s = 1; s < FETCH_DEPTH; s++) begin
                fetch_pipe[s] <= fetch_pipe[s-1];
            end
        end
    end

    assign pc_current = fetch_pipe[FETCH_DEPTH-1];

    // ------------------------------
    // Thread counter
    // ------------------------------

    // Names the thread of pc_current, strict round robin
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            thread <= '0;
        end else if (thread == THREAD_WIDTH'(THREAD_COUNT - 1)) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

endmodule

// File: sim/flow_control_vectors.svh
// One row per round of THREAD_COUNT cycles; only the target thread sees the row's status and write
`ifndef FLOW_CONTROL_VECTORS_SVH
`define FLOW_CONTROL_VECTORS_SVH

// Columns are name, target thread, random r/flags, ior, ior_previous, cancel_current, addr, data
// Threads other than the target run idle with the row's ior and no write
localparam int NUM_VECTORS = 39;

vector_t vectors [NUM_VECTORS] = '{
    '{"run after reset",       2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"stall ior low",         2, 1'b0, 1'b0, 1'b1, 1'b0, 10'h000, 32'd0},
    // Branch 0 of thread 2, taken at PC 136
    '{"b0 origin",             2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h200, 32'd136},
    '{"b0 destination",        2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h201, 32'd300},
    '{"b0 cancel clear",       2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h203, 32'd0},
    '{"b0 always",             2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_ALWAYS, 2'd0}},
    // Three writes that must not land
    '{"write while cancelled", 2, 1'b0, 1'b1, 1'b1, 1'b1, 10'h201, 32'h3ff},
    '{"write not ready",       2, 1'b0, 1'b1, 1'b0, 1'b0, 10'h201, 32'h3ff},
    '{"write outside window",  2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h208, 32'h3ff},
    '{"jump at origin",        2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    // Two-word loop 307/308, branch 1 always returns to 307
    '{"b1 origin",             2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h204, 32'd308},
    '{"b1 destination",        2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h205, 32'd307},
    '{"b1 cancel clear",       2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h207, 32'd0},
    '{"b1 always",             2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h206, {27'd0, COND_ALWAYS, 2'd0}},
    '{"b0 loop destination",   2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h201, 32'd307},
    '{"b0 loop origin",        2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h200, 32'd307},
    // Branch 0 condition swept on random status
    '{"set zero",              2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_ZERO, 2'd0}},
    '{"zero",                  2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"zero not ready",        2, 1'b1, 1'b1, 1'b0, 1'b0, 10'h000, 32'd0},
    '{"set nonzero",           2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_NONZERO, 2'd0}},
    '{"nonzero",               2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"nonzero not ready",     2, 1'b1, 1'b1, 1'b0, 1'b0, 10'h000, 32'd0},
    '{"set negative",          2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_NEGATIVE, 2'd0}},
    '{"negative",              2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"negative not ready",    2, 1'b1, 1'b1, 1'b0, 1'b0, 10'h000, 32'd0},
    '{"set positive",          2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_POSITIVE, 2'd0}},
    '{"positive",              2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"positive not ready",    2, 1'b1, 1'b1, 1'b0, 1'b0, 10'h000, 32'd0},
    '{"set flag 2",            2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_FLAG, 2'd2}},
    '{"flag",                  2, 1'b1, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"flag not ready",        2, 1'b1, 1'b1, 1'b0, 1'b0, 10'h000, 32'd0},
    // Both branches at 307, branch 0 wins until it is switched off
    '{"b0 always again",       2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h202, {27'd0, COND_ALWAYS, 2'd0}},
    '{"b0 cancel set",         2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h203, 32'd1},
    '{"b1 same origin",        2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h204, 32'd307},
    '{"b1 far destination",    2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h205, 32'd500},
    '{"both fire",             2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"b0 never",              2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h202, 32'd0},
    '{"b1 wins",               2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0},
    '{"run off",               2, 1'b0, 1'b1, 1'b1, 1'b0, 10'h000, 32'd0}
};

`endif

// File: sim/flow_control_tb.sv
// Reference model tracks PCs and settings per thread; the run stops at the first mismatch
module flow_control_tb
    import flow_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES    = 16;
    localparam int RELEASE_TIMEOUT = 8;

    // Inputs of one cycle, as seen by the aligned thread
    typedef struct packed {
        logic                   ior;
        logic                   ior_previous;
        logic                   cancel_current;
        logic [FLAGS_WIDTH-1:0] flags;
        logic [WORD_WIDTH-1:0]  r;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [WORD_WIDTH-1:0]  data;
    } stim_t;

    typedef struct {
        string                 name;
        int                    tgt;
        bit                    rnd;
        logic                  ior;
        logic                  ior_previous;
        logic                  cancel_current;
        logic [ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0] data;
    } vector_t;

    `include "flow_control_vectors.svh"

    logic clock, rst_n, ior, ior_previous, cancel_current, cancel;
    logic [FLAGS_WIDTH-1:0]  flags_previous;
    logic [WORD_WIDTH-1:0]   r_previous, config_data;
    logic [ADDR_WIDTH-1:0]   config_addr;
    logic [PC_WIDTH-1:0]     pc;
    logic [THREAD_WIDTH-1:0] thread;

    flow_control UUT (.*);

    // ------------------------------
    // Reference model state
    // ------------------------------

    int                     model_thread;
    logic [PC_WIDTH-1:0]    model_pc     [THREAD_COUNT];
    logic [PC_WIDTH-1:0]    model_origin [BRANCH_COUNT][THREAD_COUNT];
    logic [PC_WIDTH-1:0]    model_dest   [BRANCH_COUNT][THREAD_COUNT];
    logic [COND_BITS-1:0]   model_cond   [BRANCH_COUNT][THREAD_COUNT];
    logic                   model_cancel [BRANCH_COUNT][THREAD_COUNT];
    logic [31:0]            seed;
    stim_t                  idle;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s %s: expected %0h, actual %0h", test, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Condition word is op in bits 4:2 over flag select in bits 1:0
    function automatic logic cond_holds(input logic [COND_BITS-1:0] word, input stim_t s);
        logic zero;
        logic msb;
        zero = (s.r == '0);
        msb  = s.r[WORD_WIDTH-1];
        case (word[COND_BITS-1:2])
            COND_ALWAYS:   return 1'b1;
            COND_ZERO:     return s.ior_previous && zero;
            COND_NONZERO:  return s.ior_previous && !zero;
            COND_NEGATIVE: return s.ior_previous && msb;
            COND_POSITIVE: return s.ior_previous && !msb && !zero;
            COND_FLAG:     return s.ior_previous && s.flags[word[1:0]];
            default:       return 1'b0;
        endcase
    endfunction

    // ------------------------------
    // Per-cycle model and checks
    // ------------------------------

    task automatic evaluate(input string test, input stim_t s);
        int                  t;
        int                  offset;
        int                  b_sel;
        logic                fired;
        logic                exp_cancel;
        logic [PC_WIDTH-1:0] next_pc;
        t          = model_thread;
        fired      = 1'b0;
        exp_cancel = 1'b0;
        next_pc    = s.ior ? model_pc[t] + 1'b1 : model_pc[t];
        // Lowest firing branch wins
        for (int b = 0; b < BRANCH_COUNT; b++) begin
            if (!fired && s.ior && model_pc[t] == model_origin[b][t] &&
                cond_holds(model_cond[b][t], s)) begin
                fired      = 1'b1;
                exp_cancel = model_cancel[b][t];
                next_pc    = model_dest[b][t];
            end
        end
        check_value(test, "thread", t, thread);
        check_value(test, "cancel", exp_cancel, cancel);
        // pc holds the previous thread's next PC
        check_value(test, "pc", model_pc[(t + THREAD_COUNT - 1) % THREAD_COUNT], pc);
        model_pc[t] = next_pc;
        // Window write lands after this cycle's decision
        if (s.ior_previous && !s.cancel_current &&
            s.addr >= CONFIG_ADDR_BASE && s.addr <= CONFIG_ADDR_BOUND) begin
            offset = int'(s.addr - CONFIG_ADDR_BASE);
            b_sel  = offset / BRANCH_CONFIG_ENTRIES;
            case (offset % BRANCH_CONFIG_ENTRIES)
                0:       model_origin[b_sel][t] = s.data[PC_WIDTH-1:0];
                1:       model_dest[b_sel][t]   = s.data[PC_WIDTH-1:0];
                2:       model_cond[b_sel][t]   = s.data[COND_BITS-1:0];
                default: model_cancel[b_sel][t] = s.data[0];
            endcase
        end
        model_thread = (t + 1) % THREAD_COUNT;
    endtask

    task automatic make_stim(input vector_t v, output stim_t s);
        s     = idle;
        s.ior = v.ior;
        if (model_thread == v.tgt) begin
            s.ior_previous   = v.ior_previous;
            s.cancel_current = v.cancel_current;
            s.addr           = v.addr;
            s.data           = v.data;
            if (v.rnd) begin
                // Zero result about one time in four
                seed    = xorshift(seed);
                s.r     = (seed[1:0] == 2'b00) ? '0 : seed;
                seed    = xorshift(seed);
                s.flags = seed[FLAGS_WIDTH-1:0];
            end
        end
    endtask

    task automatic run_cycle(input string test, input stim_t s);
        @(posedge clock);
        ior            <= s.ior;
        ior_previous   <= s.ior_previous;
        cancel_current <= s.cancel_current;
        flags_previous <= s.flags;
        r_previous     <= s.r;
        config_addr    <= s.addr;
        config_data    <= s.data;
        // Mid-cycle, after the edge and the combinational settle
        @(negedge clock);
        evaluate(test, s);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int    waited;
        stim_t s;
        idle           = '{ior: 1'b0, ior_previous: 1'b1, default: '0};
        rst_n          = 1'b0;
        ior            = 1'b0;
        ior_previous   = 1'b1;
        cancel_current = 1'b0;
        flags_previous = '0;
        r_previous     = '0;
        config_addr    = '0;
        config_data    = '0;
        seed           = 32'h082253b4;
        model_thread   = 0;
        model_pc       = '{10'd0, 10'd64, 10'd128, 10'd192};
        for (int b = 0; b < BRANCH_COUNT; b++) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                model_origin[b][t] = '0;
                model_dest[b][t]   = '0;
                model_cond[b][t]   = '0;
                model_cancel[b][t] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        waited = 0;
        while (rst_n !== 1'b1 || $isunknown(thread)) begin
            @(negedge clock);
            waited++;
            if (waited > RELEASE_TIMEOUT) begin
                fail_run("reset release never reached the DUT");
            end
        end
        // First cycle after reset runs thread 0 with the idle inputs
        evaluate("reset idle", idle);
        foreach (vectors[i]) begin
            for (int k = 0; k < THREAD_COUNT; k++) begin
                make_stim(vectors[i], s);
                run_cycle(vectors[i].name, s);
            end
        end
        // One more cycle so the last thread's next PC is seen on pc
        run_cycle("final idle", idle);
        $display("test passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+sim
hw/flow_pkg.sv
hw/config_decoder.sv
hw/branch_unit.sv
hw/branch_arbiter.sv
hw/pc_controller.sv
hw/flow_control.sv
sim/flow_control_tb.sv
